//--- Bender.yml
package:
  name: dcache

sources:
  - src/dcache_pkg.sv
  - src/dcache_way.sv
  - src/lru_select.sv
  - src/line_mover.sv
  - src/dcache_ctrl.sv
  - src/dcache_top.sv
  - target: test
    files:
      - test/dcache_assertions.sv
      - test/tb_dcache.sv

//--- src.f
src/dcache_pkg.sv
src/dcache_way.sv
src/lru_select.sv
src/line_mover.sv
src/dcache_ctrl.sv
src/dcache_top.sv
test/dcache_assertions.sv
test/tb_dcache.sv

//--- src/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; #(
  parameter int num_ways = 6,
  localparam int way_w   = $clog2(num_ways)
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                req_valid,
  input  logic                req_write,
  input  logic                any_hit,
  input  logic [way_w-1:0]    hit_idx,        // Way holding the hit
  input  logic [way_w-1:0]    victim,         // LRU way of the set
  input  logic                victim_dirty,
  input  logic                rsp_ready,
  input  logic                rd_req_ready,
  input  logic                rd_rsp_valid,
  input  logic                rd_rsp_last,
  input  logic                wr_req_ready,
  input  logic                wr_data_ready,
  input  logic                beat_last,
  output cache_state_e        state,
  output logic                req_ready,
  output logic                rsp_valid,
  output logic                rd_req_valid,
  output logic                rd_rsp_ready,
  output logic                wr_req_valid,
  output logic                wr_data_valid,
  output logic                mover_load,
  output logic [num_ways-1:0] hit_write,
  output logic [num_ways-1:0] refill_write,
  output logic [num_ways-1:0] stamp_write
);

  cache_state_e state_next;
  logic         lookup_hit;   // Hit seen during idle lookup
  logic         refill_beat;  // Beat taken from memory
  logic         refill_done;

  assign lookup_hit  = (state == idle) && req_valid && any_hit;
  assign refill_beat = (state == refill) && rd_rsp_valid;
  assign refill_done = refill_beat && rd_rsp_last;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    unique case (state)
      idle: begin
        if (req_valid) begin
          if (any_hit) begin
            state_next = req_write ? write_hit : read_hit;
          end else begin
            state_next = victim_dirty ? wb_req : refill_req;  // Dirty victim goes out first
          end
        end
      end
      write_hit:  state_next = idle;
      read_hit:   state_next = send_rsp;
      send_rsp:   if (rsp_ready) state_next = idle;
      wb_req:     if (wr_req_ready) state_next = wb_data;
      wb_data:    if (wr_data_ready && beat_last) state_next = refill_req;
      refill_req: if (rd_req_ready) state_next = refill;
      refill: begin
        if (refill_done) state_next = req_write ? write_hit : read_hit;  // Replay as a hit
      end
      default:    state_next = idle;
    endcase
  end

  // Handshakes follow the state alone
  assign req_ready     = (state == write_hit) || (state == read_hit);
  assign rsp_valid     = (state == send_rsp);
  assign rd_req_valid  = (state == refill_req);
  assign rd_rsp_ready  = (state == refill);
  assign wr_req_valid  = (state == wb_req);
  assign wr_data_valid = (state == wb_data);
  assign mover_load    = (state == wb_req);  // Victim stable until the burst ends

  // Per-way enables
  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      hit_write[w]    = (state == write_hit) && any_hit && (hit_idx == way_w'(w));
      refill_write[w] = refill_beat && (victim == way_w'(w));
      // Stamp on a lookup hit, and on refill so the new line is not the next victim
      stamp_write[w]  = (lookup_hit && (hit_idx == way_w'(w))) ||
                        (refill_done && (victim == way_w'(w)));
    end
  end

endmodule

//--- src/dcache_pkg.sv
package dcache_pkg;

  // Address and data geometry
  localparam int addr_w         = 32;
  localparam int word_w         = 32;
  localparam int offset_w       = 5;    // Byte offset inside a 32-byte line
  localparam int words_per_line = 8;
  localparam int line_w         = 256;  // words_per_line * word_w

  // LRU last-hit timestamp width
  localparam int stamp_w = 32;

  // Burst length field for a whole line, beats minus one
  localparam logic [7:0] burst_len_line = 8'd7;

  // Controller states
  typedef enum logic [2:0] {
    idle,        // Lookup of a new request
    write_hit,   // Merge write data, ack the CPU
    read_hit,    // Capture read word, ack the CPU
    send_rsp,    // Hold the response until taken
    wb_req,      // Write-back address phase
    wb_data,     // Write-back beats
    refill_req,  // Refill address phase
    refill       // Refill beats
  } cache_state_e;

endpackage

//--- src/dcache_top.sv
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; #(
  parameter int num_sets = 8,
  parameter int num_ways = 6
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                req_valid,
  input  logic                req_write,
  input  logic [addr_w-1:0]   req_addr,
  input  logic [word_w-1:0]   req_wdata,
  input  logic [word_w/8-1:0] req_wstrb,
  output logic                req_ready,
  output logic                rsp_valid,
  output logic [word_w-1:0]   rsp_data,
  input  logic                rsp_ready,
  output logic                rd_req_valid,
  output logic [addr_w-1:0]   rd_req_addr,
  output logic [7:0]          rd_req_len,
  input  logic                rd_req_ready,
  input  logic                rd_rsp_valid,
  input  logic [word_w-1:0]   rd_rsp_data,
  input  logic                rd_rsp_last,
  output logic                rd_rsp_ready,
  output logic                wr_req_valid,
  output logic [addr_w-1:0]   wr_req_addr,
  output logic [7:0]          wr_req_len,
  input  logic                wr_req_ready,
  output logic                wr_data_valid,
  output logic [word_w-1:0]   wr_data,
  output logic [word_w/8-1:0] wr_data_strb,
  output logic                wr_data_last,
  input  logic                wr_data_ready
);

  localparam int index_w = $clog2(num_sets);
  localparam int way_w   = $clog2(num_ways);
  localparam int sel_w   = $clog2(words_per_line);
  localparam int tag_w   = addr_w - offset_w - index_w;  // 24 with 8 sets

  logic [tag_w-1:0]    tag;
  logic [index_w-1:0]  index;
  logic [sel_w-1:0]    word_sel;
  logic [num_ways-1:0] way_hit;
  logic [num_ways-1:0] way_dirty;
  logic [tag_w-1:0]    way_tag   [num_ways];
  logic [line_w-1:0]   way_line  [num_ways];
  logic [stamp_w-1:0]  way_stamp [num_ways];
  logic [num_ways-1:0] hit_write;
  logic [num_ways-1:0] refill_write;
  logic [num_ways-1:0] stamp_write;
  logic [way_w-1:0]    hit_idx;
  logic [way_w-1:0]    victim;
  logic                any_hit;
  logic                mover_load;
  logic                beat_last;
  logic [stamp_w-1:0]  stamp_ctr;  // LRU time base
  cache_state_e        state;

  assign tag      = req_addr[addr_w-1 -: tag_w];
  assign index    = req_addr[offset_w +: index_w];
  assign word_sel = req_addr[offset_w-1 -: sel_w];  // Word within the line

  for (genvar w = 0; w < num_ways; w++) begin : g_way
    dcache_way #(.num_sets(num_sets)) u_way (
      .clk, .rst, .index, .tag, .word_sel,
      .wdata(req_wdata), .wstrb(req_wstrb),
      .hit_wen(hit_write[w]), .refill_wen(refill_write[w]), .refill_data(rd_rsp_data),
      .stamp_wen(stamp_write[w]), .stamp(stamp_ctr),
      .hit(way_hit[w]), .dirty(way_dirty[w]), .line_tag(way_tag[w]),
      .line(way_line[w]), .last_hit(way_stamp[w])
    );
  end

  // One-hot hit vector to way index
  always_comb begin
    hit_idx = '0;
    for (int w = 0; w < num_ways; w++) begin
      if (way_hit[w]) hit_idx |= way_w'(w);
    end
  end

  assign any_hit = |way_hit;

  lru_select #(.num_ways(num_ways)) u_lru (.last_hit(way_stamp), .victim);

  line_mover u_mover (
    .clk, .rst, .load(mover_load), .victim_line(way_line[victim]),
    .beat_ready(wr_data_valid && wr_data_ready),
    .beat_data(wr_data), .beat_last
  );

  dcache_ctrl #(.num_ways(num_ways)) u_ctrl (
    .clk, .rst, .req_valid, .req_write, .any_hit, .hit_idx, .victim,
    .victim_dirty(way_dirty[victim]), .rsp_ready, .rd_req_ready, .rd_rsp_valid,
    .rd_rsp_last, .wr_req_ready, .wr_data_ready, .beat_last,
    .state, .req_ready, .rsp_valid, .rd_req_valid, .rd_rsp_ready, .wr_req_valid,
    .wr_data_valid, .mover_load, .hit_write, .refill_write, .stamp_write
  );

  // Counter starts at one, zero marks lines never stamped since reset
  always_ff @(posedge clk) begin
    if (rst) begin
      stamp_ctr <= stamp_w'(1);
    end else if ((state == idle) && req_valid && any_hit && (stamp_ctr != '1)) begin
      stamp_ctr <= stamp_ctr + 1'b1;  // Saturates at all ones
    end
  end

  // Read word captured in read_hit, held through send_rsp
  always_ff @(posedge clk) begin
    if (state == read_hit) rsp_data <= way_line[hit_idx][word_sel * word_w +: word_w];
  end

  assign rd_req_addr  = {req_addr[addr_w-1:offset_w], {offset_w{1'b0}}};  // Line aligned
  assign rd_req_len   = burst_len_line;
  assign wr_req_addr  = {way_tag[victim], index, {offset_w{1'b0}}};      // Victim line
  assign wr_req_len   = burst_len_line;
  assign wr_data_strb = '1;  // Full words on write-back
  assign wr_data_last = wr_data_valid && beat_last;

endmodule

//--- src/dcache_way.sv
`timescale 1ns/1ps

module dcache_way import dcache_pkg::*; #(
  parameter int num_sets = 8,
  localparam int index_w = $clog2(num_sets),
  localparam int tag_w   = addr_w - offset_w - index_w,
  localparam int sel_w   = $clog2(words_per_line)
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [index_w-1:0]    index,
  input  logic [tag_w-1:0]      tag,
  input  logic [sel_w-1:0]      word_sel,
  input  logic [word_w-1:0]     wdata,
  input  logic [word_w/8-1:0]   wstrb,
  input  logic                  hit_wen,      // CPU write merge
  input  logic                  refill_wen,   // One refill beat
  input  logic [word_w-1:0]     refill_data,
  input  logic                  stamp_wen,
  input  logic [stamp_w-1:0]    stamp,
  output logic                  hit,
  output logic                  dirty,
  output logic [tag_w-1:0]      line_tag,
  output logic [line_w-1:0]     line,
  output logic [stamp_w-1:0]    last_hit
);

  logic [num_sets-1:0] valid_q;
  logic [num_sets-1:0] dirty_q;
  logic [tag_w-1:0]    tag_q   [num_sets];
  logic [line_w-1:0]   line_q  [num_sets];
  logic [stamp_w-1:0]  stamp_q [num_sets];
  logic [line_w-1:0]   merged;               // Line with the strobed word replaced

  assign hit      = valid_q[index] && (tag_q[index] == tag);
  assign dirty    = dirty_q[index];
  assign line_tag = tag_q[index];
  assign line     = line_q[index];
  assign last_hit = stamp_q[index];

  // Byte merge under the write strobe
  always_comb begin
    merged = line_q[index];
    for (int b = 0; b < word_w / 8; b++) begin
      if (wstrb[b]) begin
        merged[word_sel * word_w + b * 8 +: 8] = wdata[b * 8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
      for (int s = 0; s < num_sets; s++) begin
        stamp_q[s] <= '0;  // Never-hit lines look oldest
      end
    end else begin
      if (refill_wen) begin
        valid_q[index] <= 1'b1;
        dirty_q[index] <= 1'b0;  // Fresh copy of memory
      end else if (hit_wen) begin
        dirty_q[index] <= 1'b1;
      end
      if (stamp_wen) stamp_q[index] <= stamp;
    end
  end

  // Tag and data storage
  always_ff @(posedge clk) begin
    if (refill_wen) begin
      tag_q[index]  <= tag;
      line_q[index] <= {refill_data, line_q[index][line_w-1:word_w]};  // Beat enters at top
    end else if (hit_wen) begin
      line_q[index] <= merged;
    end
  end

endmodule

//--- src/line_mover.sv
`timescale 1ns/1ps

module line_mover import dcache_pkg::*; #(
  localparam int beat_w = $clog2(words_per_line)
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              load,         // Capture victim line
  input  logic [line_w-1:0] victim_line,
  input  logic              beat_ready,   // Beat accepted by memory
  output logic [word_w-1:0] beat_data,
  output logic              beat_last
);

  logic [line_w-1:0] shift_q;  // Remaining words, lowest goes out first
  logic [beat_w-1:0] beat_q;   // Beats already accepted

  always_ff @(posedge clk) begin
    if (load) begin
      shift_q <= victim_line;
    end else if (beat_ready) begin
      shift_q <= {{word_w{1'b0}}, shift_q[line_w-1:word_w]};
    end
  end

  always_ff @(posedge clk) begin
    if (rst || load) begin
      beat_q <= '0;
    end else if (beat_ready) begin
      beat_q <= beat_q + 1'b1;  // Wraps after the eighth beat
    end
  end

  assign beat_data = shift_q[word_w-1:0];
  assign beat_last = (beat_q == beat_w'(words_per_line - 1));

endmodule

//--- src/lru_select.sv
`timescale 1ns/1ps

module lru_select import dcache_pkg::*; #(
  parameter int num_ways = 6,
  localparam int way_w   = $clog2(num_ways),
  localparam int leaves  = 2 ** way_w
) (
  input  logic [stamp_w-1:0] last_hit [num_ways],
  output logic [way_w-1:0]   victim
);

  // Heap-ordered tree, node n has children 2n+1 and 2n+2
  logic [stamp_w-1:0] node_val [2*leaves-1];
  logic [way_w-1:0]   node_idx [2*leaves-1];

  always_comb begin
    // Leaves, unused slots padded with the largest stamp
    for (int i = 0; i < leaves; i++) begin
      if (i < num_ways) begin
        node_val[leaves-1+i] = last_hit[i];
      end else begin
        node_val[leaves-1+i] = '1;
      end
      node_idx[leaves-1+i] = way_w'(i);
    end
    // Pairwise minimum, left child holds the lower ways so it wins ties
    for (int n = leaves - 2; n >= 0; n--) begin
      if (node_val[2*n+1] <= node_val[2*n+2]) begin
        node_val[n] = node_val[2*n+1];
        node_idx[n] = node_idx[2*n+1];
      end else begin
        node_val[n] = node_val[2*n+2];
        node_idx[n] = node_idx[2*n+2];
      end
    end
  end

  assign victim = node_idx[0];  // Root carries the oldest way

endmodule

//--- test/dcache_assertions.sv
`timescale 1ns/1ps

module dcache_assertions (
  input logic        clk,
  input logic        rst,
  input logic        req_ready,
  input logic        rsp_valid,
  input logic        rsp_ready,
  input logic [31:0] rsp_data,
  input logic        rd_req_valid,
  input logic        rd_req_ready,
  input logic [31:0] rd_req_addr,
  input logic        wr_req_valid,
  input logic        wr_req_ready,
  input logic [31:0] wr_req_addr,
  input logic        wr_data_valid,
  input logic        wr_data_ready,
  input logic        wr_data_last
);

  int         fails = 0;  // Count of failed checks
  logic [3:0] beats_q;    // Accepted write-back beats in the current burst

  always_ff @(posedge clk) begin
    if (rst || (wr_req_valid && wr_req_ready)) begin
      beats_q <= '0;
    end else if (wr_data_valid && wr_data_ready) begin
      beats_q <= beats_q + 1'b1;
    end
  end

  // Memory write and read requests held while stalled
  wr_req_stable: assert property (@(posedge clk) disable iff (rst)
    wr_req_valid && !wr_req_ready |=> wr_req_valid && $stable(wr_req_addr))
    else begin
      $error("Memory write request changed before wr_req_ready");
      fails++;
    end
  rd_req_stable: assert property (@(posedge clk) disable iff (rst)
    rd_req_valid && !rd_req_ready |=> rd_req_valid && $stable(rd_req_addr))
    else begin
      $error("Memory read request changed before rd_req_ready");
      fails++;
    end

  rsp_stable: assert property (@(posedge clk) disable iff (rst)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
    else begin
      $error("rsp_data changed before rsp_ready");
      fails++;
    end

  last_on_eighth: assert property (@(posedge clk) disable iff (rst)
    wr_data_valid && wr_data_ready |-> (wr_data_last == (beats_q == 4'd7)))
    else begin
      $error("wr_data_last not on the eighth write-back beat");
      fails++;
    end

  quiet_in_reset: assert property (@(posedge clk)
    rst && $past(rst) |-> !(req_ready || rsp_valid || rd_req_valid || wr_req_valid ||
                            wr_data_valid))
    else begin
      $error("Valid output high during reset");
      fails++;
    end

endmodule

bind dcache_top dcache_assertions u_assert (.*);

//--- test/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

  localparam int mem_words    = 1024;  // 4 KiB of backing memory
  localparam int max_accesses = 80;
  localparam int miss_cycles  = 200;   // Worst dirty miss with random stalls
  localparam int cycle_limit  = max_accesses * miss_cycles;

  logic clk, rst, req_valid, req_write, req_ready, rsp_valid, rsp_ready;
  logic [31:0] req_addr, req_wdata, rsp_data;
  logic [3:0] req_wstrb, wr_data_strb;
  logic rd_req_valid, rd_req_ready, rd_rsp_valid, rd_rsp_last, rd_rsp_ready;
  logic [31:0] rd_req_addr, rd_rsp_data, wr_req_addr, wr_data;
  logic [7:0] rd_req_len, wr_req_len, last_rd_len, last_wr_len;
  logic wr_req_valid, wr_req_ready, wr_data_valid, wr_data_last, wr_data_ready;

  int cyc, errors, rd_count, wr_count, rd_left, rd_beat, wr_beat, ctr;
  int req_start_cyc, req_ready_cyc, rsp_first_cyc;
  bit bp;  // Random stalls on every ready
  logic [31:0] mem [mem_words];
  logic [31:0] ref_mem [mem_words];  // What the CPU should see
  logic [31:0] rd_base, wr_base, last_rd_addr, last_wr_addr, rsp_word;
  bit m_valid [8][6];
  bit m_dirty [8][6];
  int m_tag [8][6];
  int m_stamp [8][6];

  dcache_top #(.num_sets(8), .num_ways(6)) dut (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  always @(posedge clk) cyc <= cyc + 1;

  initial begin
    wait (cyc >= cycle_limit);
    $display("Timeout: no finish within %0d cycles", cycle_limit);
    $display("Errors found");
    $finish;
  end

  function automatic bit ready_draw();
    return bp ? bit'($urandom_range(1, 0)) : 1'b1;
  endfunction

  task automatic value_error(input string name, input logic [31:0] got, exp);
    $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
    errors++;
  endtask

  // Burst memory, drives on the falling edge and books transfers 1 ns later
  always @(negedge clk) begin
    rd_req_ready  = ready_draw();
    wr_req_ready  = ready_draw();
    wr_data_ready = ready_draw();
    rd_rsp_valid  = (rd_left > 0) && ready_draw();
    rd_rsp_data   = mem[rd_base + rd_beat];
    rd_rsp_last   = rd_rsp_valid && (rd_beat == 7);
    #1;
    if (rd_req_valid && rd_req_ready) begin
      last_rd_addr = rd_req_addr;
      last_rd_len  = rd_req_len;
      rd_base      = rd_req_addr[11:2];
      rd_left      = 8;
      rd_beat      = 0;
      rd_count++;
    end else if (rd_rsp_valid && rd_rsp_ready) begin
      rd_beat++;
      rd_left--;
    end
    if (wr_req_valid && wr_req_ready) begin
      last_wr_addr = wr_req_addr;
      last_wr_len  = wr_req_len;
      wr_base      = wr_req_addr[11:2];
      wr_beat      = 0;
      wr_count++;
    end
    if (wr_data_valid && wr_data_ready) begin
      assert (wr_data == ref_mem[wr_base + wr_beat])
        else value_error("wr_data", wr_data, ref_mem[wr_base + wr_beat]);
      assert (wr_data_last == (wr_beat == 7))
        else value_error("wr_data_last", wr_data_last, wr_beat == 7);
      assert (wr_data_strb == 4'hf) else value_error("wr_data_strb", wr_data_strb, 4'hf);
      mem[wr_base + wr_beat] = wr_data;
      wr_beat++;
    end
  end

  // One CPU access, checked against the tag model and the reference memory
  task automatic cpu_access(input bit wr, input logic [31:0] addr, wd, input logic [3:0] ws);
    int set, tag, way, vic, rd0, wr0;
    bit hit, wb, seen, done;
    logic [31:0] exp_wb;
    set = addr[7:5];
    tag = addr[31:8];
    hit = 0;
    way = 0;
    vic = 0;
    for (int w = 0; w < 6; w++) begin
      if (m_valid[set][w] && m_tag[set][w] == tag) begin
        hit = 1;
        way = w;
      end
      if (m_stamp[set][w] < m_stamp[set][vic]) vic = w;  // Strict, lowest way keeps ties
    end
    wb     = !hit && m_valid[set][vic] && m_dirty[set][vic];
    exp_wb = (m_tag[set][vic] << 8) | (set << 5);
    rd0    = rd_count;
    wr0    = wr_count;
    req_valid = 1'b1;
    req_write = wr;
    req_addr  = addr;
    req_wdata = wd;
    req_wstrb = ws;
    req_start_cyc = cyc;
    do @(negedge clk); while (!req_ready);
    req_ready_cyc = cyc;
    @(negedge clk);
    req_valid = 1'b0;
    if (!wr) begin
      seen = 0;
      done = 0;
      while (!done) begin
        rsp_ready = ready_draw();
        if (rsp_valid && !seen) begin
          seen = 1;
          rsp_first_cyc = cyc;
        end
        if (rsp_valid && rsp_ready) begin
          rsp_word = rsp_data;
          done = 1;
        end
        @(negedge clk);
      end
      rsp_ready = 1'b0;
    end
    assert (rd_count - rd0 == (hit ? 0 : 1)) else value_error("read bursts", rd_count - rd0, !hit);
    assert (wr_count - wr0 == (wb ? 1 : 0)) else value_error("write bursts", wr_count - wr0, wb);
    if (!hit) begin
      assert (last_rd_addr == {addr[31:5], 5'b0})
        else value_error("rd_req_addr", last_rd_addr, {addr[31:5], 5'b0});
      assert (last_rd_len == 8'd7) else value_error("rd_req_len", last_rd_len, 8'd7);
    end
    if (wb) begin
      assert (last_wr_addr == exp_wb) else value_error("wr_req_addr", last_wr_addr, exp_wb);
      assert (last_wr_len == 8'd7) else value_error("wr_req_len", last_wr_len, 8'd7);
    end
    if (!wr) begin
      assert (rsp_word == ref_mem[addr[11:2]])
        else value_error("rsp_data", rsp_word, ref_mem[addr[11:2]]);
    end
    if (hit) begin
      m_stamp[set][way] = ctr;
      ctr++;
    end else begin
      way = vic;
      m_valid[set][way] = 1;
      m_tag[set][way]   = tag;
      m_dirty[set][way] = 0;
      m_stamp[set][way] = ctr;  // Refill stamps without advancing the counter
    end
    if (wr) begin
      m_dirty[set][way] = 1;
      for (int b = 0; b < 4; b++) begin
        if (ws[b]) ref_mem[addr[11:2]][b*8 +: 8] = wd[b*8 +: 8];
      end
    end
  endtask

  task automatic clean_read_miss();
    cpu_access(0, 32'h0000_0148, '0, '0);  // Set 2, tag 1, word 2
  endtask

  task automatic read_hit_timing();
    cpu_access(0, 32'h0000_0148, '0, '0);
    assert (req_ready_cyc == req_start_cyc + 1 && rsp_first_cyc == req_start_cyc + 2) else begin
      $display("Error at %0t: read hit response not two cycles after the lookup", $time);
      errors++;
    end
  endtask

  task automatic strobed_write();
    cpu_access(1, 32'h0000_0148, 32'hdead_beef, 4'b0101);
    cpu_access(0, 32'h0000_0148, '0, '0);
    cpu_access(1, 32'h0000_0264, 32'h1234_5678, 4'b1110);  // Uncached, allocates first
    cpu_access(0, 32'h0000_0264, '0, '0);
  endtask

  task automatic dirty_eviction();
    for (int t = 1; t <= 6; t++) cpu_access(0, (t << 8) | 32'ha4, '0, '0);
    cpu_access(1, 32'h0000_01a8, 32'hcafe_f00d, 4'b1111);  // Tag 1 goes dirty
    for (int t = 2; t <= 6; t++) cpu_access(0, (t << 8) | 32'ha4, '0, '0);
    cpu_access(0, 32'h0000_07a4, '0, '0);  // Seventh tag evicts dirty tag 1
    cpu_access(0, 32'h0000_01a8, '0, '0);  // Merged word back from memory
  endtask

  task automatic random_traffic();
    logic [31:0] addr;
    bp = 1;
    repeat (40) begin
      addr = ($urandom_range(8, 1) << 8) | ($urandom_range(1, 0) << 5) |
             ($urandom_range(7, 0) << 2);
      cpu_access(bit'($urandom_range(1, 0)), addr, $urandom, 4'($urandom_range(15, 1)));
    end
  endtask

  initial begin
    void'($urandom(44));
    rst = 1'b1;
    {req_valid, req_write, rsp_ready} = '0;
    {req_addr, req_wdata, req_wstrb} = '0;
    {rd_req_ready, rd_rsp_valid, rd_rsp_last, rd_rsp_data} = '0;
    {wr_req_ready, wr_data_ready} = '0;
    {cyc, errors, rd_count, wr_count, rd_left, rd_beat, wr_beat} = '0;
    ctr = 1;
    bp  = 0;
    for (int i = 0; i < mem_words; i++) begin
      mem[i]     = (i * 4) ^ 32'h5a3c_96e1;
      ref_mem[i] = mem[i];
    end
    repeat (10) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    clean_read_miss();
    read_hit_timing();
    strobed_write();
    dirty_eviction();
    random_traffic();
    $display("Tests done with %0d errors and %0d assertion failures", errors,
             dut.u_assert.fails);
    if (errors == 0 && dut.u_assert.fails == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
